// ==== all.f ====
verilog/emmc_pkg.sv
verilog/sd_lane_map.sv
verilog/rx_bitslip_lane.sv
verilog/bitslip_align_ctrl.sv
verilog/emmc_serdes_top.sv
tests/emmc_serdes_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the eMMC bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module emmc_serdes_tb \
   -f all.f -o emmc_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/emmc_sim > sim.log 2>&1 ; cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "No result in sim.log"; exit 1; }
exit 0

// ==== tests/emmc_serdes_tb.sv ====
`default_nettype none

module emmc_serdes_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [7:0] pattern = emmc_pkg::default_align_pattern;
   localparam int tx_count   = 200;   // Random host words in the transmit test
   localparam int lock_limit = 40;    // Cycles allowed to reach lock
   localparam int data_count = 100;   // Checked words after each lock
   localparam int fall_limit = 8;     // Cycles for link_aligned to drop
   localparam int pre_change = 20;    // Words before the phase jump

   // Test lengths in cycles summed for the watchdog
   localparam int len_reset  = 5 + 3;
   localparam int len_tx     = tx_count + 2;
   localparam int len_phase  = 8 * (5 + lock_limit + 2 + data_count);
   localparam int len_change = 5 + 2 * lock_limit + pre_change + fall_limit + 2 + data_count;
   localparam int cycle_limit = len_reset + len_tx + len_phase + len_change + 64;

   // DUT ports
   logic       txclk_div;
   logic       rst;
   logic       cmd_o;
   logic       cmd_t;
   logic       sd_dat_t;
   logic [3:0] sd_dat_o;
   logic [7:0] rx_clk_word;
   logic [7:0] rx_data_word;
   logic [7:0] tx_data_word;
   logic       cmd_i;
   logic [3:0] sd_dat_i;
   logic       link_aligned;

   logic [31:0] lcg_state;             // Random generator state
   logic [7:0]  orig_mem [0:4095];     // Original data words of the stream
   int          sidx;                  // Index of the next raw word to drive
   int          phase;                 // Bit skew of both lanes
   int          errors;
   int          checks;
   int          tests_run;
   int          cycles;                // Watchdog count

   emmc_serdes_top #(
      .align_pattern (pattern)
   ) dut0 (
      .txclk_div    (txclk_div),
      .rst          (rst),
      .cmd_o        (cmd_o),
      .cmd_t        (cmd_t),
      .sd_dat_t     (sd_dat_t),
      .sd_dat_o     (sd_dat_o),
      .rx_clk_word  (rx_clk_word),
      .rx_data_word (rx_data_word),
      .tx_data_word (tx_data_word),
      .cmd_i        (cmd_i),
      .sd_dat_i     (sd_dat_i),
      .link_aligned (link_aligned)
   );

   always #20 txclk_div = ~txclk_div;   // 40 ns word clock

   // Watchdog
   always @(posedge txclk_div) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // LCG step returning the upper byte
   function automatic logic [7:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:24];
   endfunction

   // Transmit layout from bit 0 up is cmd_o, cmd_t, sd_dat_t and the data nibble
   function automatic logic [7:0] pack_host(input logic co, input logic ct,
                                            input logic dt, input logic [3:0] dout);
      return {1'b0, dout, dt, ct, co};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - err_before);
   endtask

   // One cycle of both lanes at the current phase
   // Raw word n holds stream bits 8n+phase to 8n+phase+7
   task automatic step_stream();
      logic [15:0] pair;
      @(negedge txclk_div);
      pair = {orig_mem[sidx + 1], orig_mem[sidx]} >> phase;
      rx_data_word = pair[7:0];
      pair = {pattern, pattern} >> phase;   // Training word every word
      rx_clk_word = pair[7:0];
      sidx++;
   endtask

   // Recovered host bits against the stream model
   task automatic check_data();
      int last;
      int exp_idx;
      last = sidx - 1;                                   // Word driven this cycle
      exp_idx = (phase == 0) ? last - 3 : last - 2;      // One word later when unskewed
      check_value("cmd_i", cmd_i, orig_mem[exp_idx][0]);
      check_value("sd_dat_i", sd_dat_i, orig_mem[exp_idx][4:1]);
   endtask

   // Four reset cycles with the stream and host pins still moving
   task automatic apply_reset();
      int n;
      logic [7:0] host;
      for (n = 0; n < 5; n++) begin
         step_stream();
         if (n > 0) begin   // Reset edge has been seen
            check_value("tx_data_word", tx_data_word, 0);
            check_value("cmd_i", cmd_i, 0);
            check_value("sd_dat_i", sd_dat_i, 0);
            check_value("link_aligned", link_aligned, 0);
         end
         host = next_rand();   // Host pins keep toggling under reset
         cmd_o    = host[0];
         cmd_t    = host[1];
         sd_dat_t = host[2];
         sd_dat_o = host[6:3];
         rst = (n == 4);   // Released on the fifth falling edge
      end
   endtask

   // Lock needs two high samples in a row
   task automatic wait_lock(output bit locked);
      int n;
      int run;
      locked = 1'b0;
      run = 0;
      for (n = 0; n < lock_limit && !locked; n++) begin
         step_stream();
         run = link_aligned ? run + 1 : 0;
         if (run >= 2)
            locked = 1'b1;
      end
      checks++;
      assert (locked) else begin
         $display("Lock timeout: link_aligned not steady high within %0d cycles, phase %0d",
                  lock_limit, phase);
         errors++;
      end
   endtask

   // Lock held and data following the model
   task automatic check_locked_stream(input int count);
      int n;
      for (n = 0; n < count; n++) begin
         step_stream();
         check_value("link_aligned", link_aligned, 1);
         check_data();
      end
   endtask

   initial begin
      int i;
      int p;
      int err_before;
      bit locked;
      bit fell;
      logic [7:0] host;
      logic [7:0] exp_tx;

      txclk_div    = 1'b0;
      rst          = 1'b1;   // Asserted from the first falling edge
      cmd_o        = 1'b0;
      cmd_t        = 1'b0;
      sd_dat_t     = 1'b0;
      sd_dat_o     = 4'h0;
      rx_clk_word  = 8'h00;
      rx_data_word = 8'h00;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      cycles       = 0;
      sidx         = 4;   // Model looks up to four words back
      phase        = 0;
      lcg_state    = 32'h48e3_cf30;
      for (i = 0; i < 4096; i++)
         orig_mem[i] = next_rand();

      // Reset values
      err_before = errors;
      apply_reset();
      report_test("reset state", err_before);

      // Transmit packing one cycle behind the host pins
      err_before = errors;
      exp_tx = pack_host(cmd_o, cmd_t, sd_dat_t, sd_dat_o);   // Pins set at reset release
      for (i = 0; i < tx_count; i++) begin
         step_stream();
         check_value("tx_data_word", tx_data_word, exp_tx);
         host = next_rand();
         cmd_o    = host[0];
         cmd_t    = host[1];
         sd_dat_t = host[2];
         sd_dat_o = host[6:3];
         exp_tx = pack_host(host[0], host[1], host[2], host[6:3]);
      end
      step_stream();
      check_value("tx_data_word", tx_data_word, exp_tx);
      report_test("transmit packing", err_before);

      // Lock and data recovery for every skew
      for (p = 0; p < 8; p++) begin
         err_before = errors;
         phase = p;
         apply_reset();
         wait_lock(locked);
         if (locked) begin
            step_stream();   // Let the lane map catch up
            step_stream();
            check_locked_stream(data_count);
         end
         report_test($sformatf("phase %0d lock and data", p), err_before);
      end

      // Skew jump without reset
      err_before = errors;
      phase = 3;
      apply_reset();
      wait_lock(locked);
      if (locked)
         check_locked_stream(pre_change);
      phase = 6;
      fell = 1'b0;
      for (i = 0; i < fall_limit && !fell; i++) begin
         step_stream();
         if (!link_aligned)
            fell = 1'b1;
      end
      checks++;
      assert (fell) else begin
         $display("Lock loss missed: link_aligned stayed high after the phase change");
         errors++;
      end
      wait_lock(locked);
      if (locked) begin
         step_stream();
         step_stream();
         check_locked_stream(data_count);
      end
      report_test("phase change relock", err_before);

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/emmc_serdes_top.sv ====
`default_nettype none

module emmc_serdes_top #(
   // Training word expected on the clock lane
   parameter logic [emmc_pkg::word_width-1:0] align_pattern = emmc_pkg::default_align_pattern
) (
   input  wire logic                            txclk_div,      // Word clock
   input  wire logic                            rst,            // Sync, active low
   // Host transmit side
   input  wire logic                            cmd_o,
   input  wire logic                            cmd_t,
   input  wire logic                            sd_dat_t,
   input  wire logic [emmc_pkg::sd_width-1:0]   sd_dat_o,
   // Raw deserialized lanes
   input  wire logic [emmc_pkg::word_width-1:0] rx_clk_word,
   input  wire logic [emmc_pkg::word_width-1:0] rx_data_word,
   // Line and host receive side
   output logic [emmc_pkg::word_width-1:0]      tx_data_word,
   output logic                                 cmd_i,
   output logic [emmc_pkg::sd_width-1:0]        sd_dat_i,
   output logic                                 link_aligned
);

   logic                            bitslip;        // Shared slip strobe
   logic [emmc_pkg::word_width-1:0] clk_aligned;    // Clock lane after barrel
   logic [emmc_pkg::word_width-1:0] data_aligned;   // Data lane after barrel

   // Clock lane, carries the training word
   rx_bitslip_lane clk_lane0 (
      .txclk_div    (txclk_div),
      .rst          (rst),
      .bitslip      (bitslip),
      .raw_word     (rx_clk_word),
      .aligned_word (clk_aligned)
   );

   // Data lane slips in step with the clock lane
   // Both lanes share the same skew, so one controller serves both
   rx_bitslip_lane data_lane0 (
      .txclk_div    (txclk_div),
      .rst          (rst),
      .bitslip      (bitslip),
      .raw_word     (rx_data_word),
      .aligned_word (data_aligned)
   );

   // Alignment search on the clock lane
   bitslip_align_ctrl #(
      .align_pattern (align_pattern)
   ) align0 (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .clk_lane_word (clk_aligned),
      .bitslip       (bitslip),
      .link_aligned  (link_aligned)
   );

   // Host side packing and unpacking
   sd_lane_map map0 (
      .txclk_div    (txclk_div),
      .rst          (rst),
      .cmd_o        (cmd_o),
      .cmd_t        (cmd_t),
      .sd_dat_t     (sd_dat_t),
      .sd_dat_o     (sd_dat_o),
      .rx_word      (data_aligned),
      .tx_data_word (tx_data_word),
      .cmd_i        (cmd_i),
      .sd_dat_i     (sd_dat_i)
   );

endmodule

`default_nettype wire

// ==== verilog/bitslip_align_ctrl.sv ====
`default_nettype none

module bitslip_align_ctrl #(
   parameter logic [emmc_pkg::word_width-1:0] align_pattern = emmc_pkg::default_align_pattern
) (
   input  wire logic                            txclk_div,
   input  wire logic                            rst,            // Sync, active low
   input  wire logic [emmc_pkg::word_width-1:0] clk_lane_word,  // Aligned clock lane
   output logic                                 bitslip,        // To both lanes
   output logic                                 link_aligned
);

   emmc_pkg::bitslip_state_e state;
   logic                     match;

   // Clock lane carries the training word every cycle once aligned
   assign match = (clk_lane_word == align_pattern);

   // Lock flag, one cycle behind the lane word
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         link_aligned <= 1'b0;
      end else begin
         link_aligned <= match;
      end
   end

   // Slip sequencer
   // Pulse, then wait two cycles for the lane to present the slipped word
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         state   <= emmc_pkg::slip_idle;
         bitslip <= 1'b0;
      end else if (match) begin
         state   <= emmc_pkg::slip_idle;   // Locked, hold offset
         bitslip <= 1'b0;
      end else begin
         case (state)
            emmc_pkg::slip_idle: begin
               bitslip <= 1'b1;   // Launch one slip
               state   <= emmc_pkg::slip_pulse;
            end
            emmc_pkg::slip_pulse: begin
               bitslip <= 1'b0;   // Offset advances at this edge
               state   <= emmc_pkg::slip_settle;
            end
            emmc_pkg::slip_settle: begin
               bitslip <= 1'b0;
               state   <= emmc_pkg::slip_check;
            end
            emmc_pkg::slip_check: begin
               // Word seen here already uses the new offset
               bitslip <= 1'b0;
               state   <= emmc_pkg::slip_idle;
            end
            default: begin
               bitslip <= 1'b0;
               state   <= emmc_pkg::slip_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_bitslip_lane.sv ====
`default_nettype none

module rx_bitslip_lane (
   input  wire logic                            txclk_div,
   input  wire logic                            rst,          // Sync, active low
   input  wire logic                            bitslip,      // One-cycle strobe
   input  wire logic [emmc_pkg::word_width-1:0] raw_word,     // Deserialized, unaligned
   output logic [emmc_pkg::word_width-1:0]      aligned_word
);

   logic [emmc_pkg::word_width-1:0]   prev_word;   // Raw word of last cycle
   logic [emmc_pkg::slip_width-1:0]   offset;      // Current barrel position
   logic [2*emmc_pkg::word_width-1:0] window;      // Two words back to back

   // Previous word in the low half, so lower stream bits sit at lower indices
   assign window = {raw_word, prev_word};

   // History register
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         prev_word <= '0;
      end else begin
         prev_word <= raw_word;
      end
   end

   // Slip offset, wraps after word_width slips
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         offset <= '0;
      end else if (bitslip) begin
         offset <= offset + 1'b1;   // Natural wrap of slip_width bits
      end
   end

   // Barrel select, registered
   // Selection uses the offset held before this edge, new offset shows next cycle
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         aligned_word <= '0;
      end else begin
         aligned_word <= window[offset +: emmc_pkg::word_width];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/sd_lane_map.sv ====
`default_nettype none

module sd_lane_map (
   input  wire logic                          txclk_div,
   input  wire logic                          rst,         // Sync, active low
   // Host side, transmit
   input  wire logic                          cmd_o,
   input  wire logic                          cmd_t,
   input  wire logic                          sd_dat_t,
   input  wire logic [emmc_pkg::sd_width-1:0]   sd_dat_o,
   // Aligned word from the data lane
   input  wire logic [emmc_pkg::word_width-1:0] rx_word,
   output logic [emmc_pkg::word_width-1:0]      tx_data_word,
   output logic                                cmd_i,
   output logic [emmc_pkg::sd_width-1:0]        sd_dat_i
);

   // Transmit packing, one cycle from host pins to line word
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         tx_data_word <= '0;
      end else begin
         tx_data_word <= '0;   // Spare top bit stays low
         tx_data_word[emmc_pkg::bit_cmd_o] <= cmd_o;
         tx_data_word[emmc_pkg::bit_cmd_t] <= cmd_t;
         tx_data_word[emmc_pkg::bit_dat_t] <= sd_dat_t;
         tx_data_word[emmc_pkg::bit_dat_lo +: emmc_pkg::sd_width] <= sd_dat_o;
      end
   end

   // Receive unpacking
   // Tristate bits of the far end are not carried back, only cmd and data
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         cmd_i    <= 1'b0;
         sd_dat_i <= '0;
      end else begin
         cmd_i    <= rx_word[emmc_pkg::bit_rx_cmd];
         sd_dat_i <= rx_word[emmc_pkg::bit_rx_dat_lo +: emmc_pkg::sd_width];
      end
   end

   // Bits 5 to 7 of rx_word are spare on this link

endmodule

`default_nettype wire

// ==== verilog/emmc_pkg.sv ====
`default_nettype none

package emmc_pkg;

   // Line word and bus widths
   localparam int word_width = 8;   // Bits per deserialized line word
   localparam int sd_width   = 4;   // SD data bus, low nibble only
   localparam int slip_width = 3;   // Barrel offset, 0 to word_width-1

   // Transmit word layout
   // Bit 7 is left at zero
   localparam int bit_cmd_o  = 0;   // Command out
   localparam int bit_cmd_t  = 1;   // Command tristate
   localparam int bit_dat_t  = 2;   // Data tristate
   localparam int bit_dat_lo = 3;   // sd_dat_o occupies bits 3 to 6

   // Receive word layout, after alignment
   localparam int bit_rx_cmd    = 0;   // Command in
   localparam int bit_rx_dat_lo = 1;   // sd_dat_i taken from bits 1 to 4

   // Training word sent on the clock lane
   // All eight rotations of 8'hC3 differ, so only one offset can match
   localparam logic [word_width-1:0] default_align_pattern = 8'hC3;

   // Bitslip controller states
   // One full pass through the four states costs one slip
   typedef enum logic [1:0] {
      slip_idle   = 2'd0,   // Compare and launch a slip on mismatch
      slip_pulse  = 2'd1,   // bitslip high during this state
      slip_settle = 2'd2,   // Lane loads word at new offset
      slip_check  = 2'd3    // Slipped word visible at controller
   } bitslip_state_e;

endpackage

`default_nettype wire
